/* cdc_handshake.sv */
module cdc_handshake (
    input  logic                   in_clk,
    input  logic                   reset,
    input  logic                   desc_valid,
    input  switch_pkg::pkt_desc_t  desc,
    output logic                   desc_ready,
    input  logic                   out_clk,
    output logic                   rx_valid,
    input  logic                   rx_ready,
    output switch_pkg::pkt_desc_t  rx_desc
);

    import switch_pkg::*;

    pkt_desc_t hold;
    logic      busy;
    logic      req_tgl;
    logic      ack_s1;
    logic      ack_s2;
    logic      ack_s3;
    logic      req_s1;
    logic      req_s2;
    logic      req_s3;
    logic      ack_tgl;
    logic      take;

    assign take       = desc_valid && !busy;
    assign desc_ready = !busy;

    // hold does not change until the acknowledge is back, so it is read directly
    assign rx_desc = hold;

    always_ff @(posedge in_clk) begin
        if (reset) begin
            busy    <= 1'b0;
            req_tgl <= 1'b0;
            ack_s1  <= 1'b0;
            ack_s2  <= 1'b0;
            ack_s3  <= 1'b0;
        end else begin
            ack_s1 <= ack_tgl;
            ack_s2 <= ack_s1;
            ack_s3 <= ack_s2;
            if (take) begin
                busy    <= 1'b1;
                req_tgl <= ~req_tgl;
            end else if (ack_s2 != ack_s3) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (take) begin
            hold <= desc;
        end
    end

    always_ff @(posedge out_clk) begin
        if (reset) begin
            req_s1   <= 1'b0;
            req_s2   <= 1'b0;
            req_s3   <= 1'b0;
            ack_tgl  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            req_s1 <= req_tgl;
            req_s2 <= req_s1;
            req_s3 <= req_s2;
            if (req_s2 != req_s3) begin
                rx_valid <= 1'b1;
            end else if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
                ack_tgl  <= ~ack_tgl;
            end
        end
    end

endmodule

/* crc16_32bit.sv */
module crc16_32bit (
    input  logic               in_clk,
    input  logic               reset,
    input  logic               clear,
    input  logic               crc_en,
    input  switch_pkg::data_t  data_in,
    output switch_pkg::crc_t   crc_out
);

    import switch_pkg::*;

    crc_t crc_next;

    // one word folded bit by bit, msb first, unrolled into a single cycle
    function automatic crc_t crc_fold(crc_t c, data_t d);
        crc_t r;
        r = c;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            if (r[CRC_WIDTH-1] ^ d[i]) begin
                r = (r << 1) ^ CRC_POLY;
            end else begin
                r = r << 1;
            end
        end
        return r;
    endfunction

    assign crc_next = crc_fold(crc_out, data_in);

    always_ff @(posedge in_clk) begin
        if (reset || clear) begin
            crc_out <= CRC_INIT;
        end else if (crc_en) begin
            crc_out <= crc_next;
        end
    end

endmodule

/* dc_fifo.sv */
module dc_fifo (
    input  logic               in_clk,
    input  logic               reset,
    input  logic               wr_en,
    input  switch_pkg::data_t  wr_data,
    output logic               full,
    input  logic               out_clk,
    input  logic               rd_en,
    output switch_pkg::data_t  rd_data,
    output logic               empty
);

    import switch_pkg::*;

    data_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_bin;
    fifo_ptr_t wr_gray;
    fifo_ptr_t wr_bin_next;
    fifo_ptr_t rd_gray_s1;
    fifo_ptr_t rd_gray_s2;
    fifo_ptr_t rd_bin;
    fifo_ptr_t rd_gray;
    fifo_ptr_t rd_bin_next;
    fifo_ptr_t wr_gray_s1;
    fifo_ptr_t wr_gray_s2;
    logic      wr_push;
    logic      rd_pop;

    function automatic fifo_ptr_t bin2gray(fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side, in_clk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wr_push     = wr_en && !full;
    assign wr_bin_next = wr_bin + 1'b1;

    // full when the gray pointers differ only in their top two bits
    assign full = (wr_gray == {~rd_gray_s2[FIFO_AW:FIFO_AW-1], rd_gray_s2[FIFO_AW-2:0]});

    always_ff @(posedge in_clk) begin
        if (reset) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_push) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= bin2gray(wr_bin_next);
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (wr_push) begin
            mem[wr_bin[FIFO_AW-1:0]] <= wr_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side, out_clk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_pop      = rd_en && !empty;
    assign rd_bin_next = rd_bin + 1'b1;
    assign empty       = (rd_gray == wr_gray_s2);

    // head word is shown before it is popped
    assign rd_data = mem[rd_bin[FIFO_AW-1:0]];

    always_ff @(posedge out_clk) begin
        if (reset) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (rd_pop) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= bin2gray(rd_bin_next);
            end
        end
    end

endmodule

/* files.f */
switch_pkg.sv
crc16_32bit.sv
in_wr_controller_fsm.sv
dc_fifo.sv
cdc_handshake.sv
in_rd_controller_fsm.sv
in_module.sv
tb_in_module.sv

/* in_module.sv */
module in_module (
    input  logic                   in_clk,
    input  logic                   out_clk,
    input  logic                   reset,
    input  logic                   wr_sop,
    input  logic                   wr_eop,
    input  logic                   wr_vld,
    input  switch_pkg::data_t      wr_data,
    output logic                   wr_ready,
    input  logic                   ready_in,
    output logic                   vld,
    output switch_pkg::data_t      data,
    output switch_pkg::port_sel_t  rx
);

    import switch_pkg::*;

    logic      wr_en;
    logic      fifo_full;
    logic      desc_valid;
    logic      desc_ready;
    pkt_desc_t tx_desc;
    logic      rx_valid;
    logic      rx_ready;
    pkt_desc_t rx_desc;
    data_t     fifo_rd_data;
    logic      fifo_empty;
    logic      fifo_rd_en;

    in_wr_controller_fsm u_wr_ctrl (
        .in_clk     (in_clk),
        .reset      (reset),
        .wr_sop     (wr_sop),
        .wr_eop     (wr_eop),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .full       (fifo_full),
        .wr_en      (wr_en),
        .desc_valid (desc_valid),
        .desc       (tx_desc),
        .desc_ready (desc_ready)
    );

    dc_fifo u_fifo (
        .in_clk  (in_clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (fifo_full),
        .out_clk (out_clk),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    cdc_handshake u_cdc (
        .in_clk     (in_clk),
        .reset      (reset),
        .desc_valid (desc_valid),
        .desc       (tx_desc),
        .desc_ready (desc_ready),
        .out_clk    (out_clk),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_desc    (rx_desc)
    );

    in_rd_controller_fsm u_rd_ctrl (
        .out_clk  (out_clk),
        .reset    (reset),
        .rx_valid (rx_valid),
        .rx_desc  (rx_desc),
        .rx_ready (rx_ready),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .rd_en    (fifo_rd_en),
        .vld      (vld),
        .ready_in (ready_in),
        .data     (data),
        .rx       (rx)
    );

endmodule

/* in_rd_controller_fsm.sv */
module in_rd_controller_fsm (
    input  logic                   out_clk,
    input  logic                   reset,
    input  logic                   rx_valid,
    input  switch_pkg::pkt_desc_t  rx_desc,
    output logic                   rx_ready,
    input  switch_pkg::data_t      rd_data,
    input  logic                   empty,
    output logic                   rd_en,
    output logic                   vld,
    input  logic                   ready_in,
    output switch_pkg::data_t      data,
    output switch_pkg::port_sel_t  rx
);

    import switch_pkg::*;

    typedef enum logic [1:0] {
        idle,
        ctrl,
        drain
    } rd_state_t;

    rd_state_t state;
    pkt_desc_t desc_q;
    length_t   count;

    always_comb begin
        rx_ready = 1'b0;
        vld      = 1'b0;
        rd_en    = 1'b0;
        data     = rd_data;
        case (state)
            idle: begin
                rx_ready = rx_valid;
            end
            ctrl: begin
                vld  = 1'b1;
                data = ctrl_word(desc_q);
            end
            drain: begin
                vld   = !empty;
                rd_en = !empty && ready_in;
            end
            default: begin
                vld = 1'b0;
            end
        endcase
    end

    always_ff @(posedge out_clk) begin
        if (reset) begin
            state <= idle;
            rx    <= '0;
            count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (rx_valid) begin
                        rx    <= rx_desc.dest;
                        state <= ctrl;
                    end
                end
                ctrl: begin
                    if (ready_in) begin
                        count <= desc_q.length;
                        state <= drain;
                    end
                end
                drain: begin
                    if (rd_en) begin
                        count <= count - 1'b1;
                        // last payload word of this packet
                        if (count == length_t'(1)) begin
                            state <= idle;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge out_clk) begin
        if (state == idle && rx_valid) begin
            desc_q <= rx_desc;
        end
    end

endmodule

/* in_wr_controller_fsm.sv */
module in_wr_controller_fsm (
    input  logic                   in_clk,
    input  logic                   reset,
    input  logic                   wr_sop,
    input  logic                   wr_eop,
    input  logic                   wr_vld,
    input  switch_pkg::data_t      wr_data,
    output logic                   wr_ready,
    input  logic                   full,
    output logic                   wr_en,
    output logic                   desc_valid,
    output switch_pkg::pkt_desc_t  desc,
    input  logic                   desc_ready
);

    import switch_pkg::*;

    typedef enum logic [1:0] {
        idle,
        payload,
        issue
    } wr_state_t;

    wr_state_t state;
    logic      accept;
    logic      crc_clear;
    pkt_desc_t hdr_q;
    crc_t      crc_out;

    // no input is taken while the finished descriptor waits for the crossing
    assign wr_ready   = (state != issue) && !full;
    assign accept     = wr_vld && wr_ready;
    assign crc_clear  = (state == idle) && accept && wr_sop;
    assign wr_en      = (state == payload) && accept;
    assign desc_valid = (state == issue);

    always_ff @(posedge in_clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (accept && wr_sop) begin
                        state <= payload;
                    end
                end
                payload: begin
                    if (accept && wr_eop) begin
                        state <= issue;
                    end
                end
                issue: begin
                    if (desc_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge in_clk) begin
        if (crc_clear) begin
            hdr_q <= header_decode(wr_data);
        end
    end

    // the crc register already holds the eop word when issue is entered
    always_comb begin
        desc     = hdr_q;
        desc.crc = crc_out;
    end

    crc16_32bit u_crc (
        .in_clk  (in_clk),
        .reset   (reset),
        .clear   (crc_clear),
        .crc_en  (wr_en),
        .data_in (wr_data),
        .crc_out (crc_out)
    );

endmodule

/* switch_pkg.sv */
package switch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // switch dimensions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_WIDTH      = 32;
    localparam int PORT_NUM        = 16;
    localparam int PRIORITY_LEVELS = 8;
    localparam int DATA_LENGTH_MAX = 256;
    localparam int FIFO_DEPTH      = 256;

    localparam int SEL_WIDTH    = $clog2(PORT_NUM);
    localparam int PRIO_WIDTH   = $clog2(PRIORITY_LEVELS);
    localparam int LENGTH_WIDTH = $clog2(DATA_LENGTH_MAX);
    localparam int CRC_WIDTH    = 16;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [SEL_WIDTH-1:0]    port_sel_t;
    typedef logic [PRIO_WIDTH-1:0]   priority_t;
    typedef logic [LENGTH_WIDTH-1:0] length_t;
    typedef logic [CRC_WIDTH-1:0]    crc_t;

    // one extra bit over the address tells a full FIFO from an empty one
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    // CRC-16/CCITT
    localparam crc_t CRC_POLY = 16'h1021;
    localparam crc_t CRC_INIT = 16'hFFFF;

    typedef struct packed {
        crc_t      crc;
        port_sel_t dest;
        priority_t prio;
        length_t   length;
    } pkt_desc_t;

    // header word: length 7..0, priority 10..8, dest 14..11
    function automatic pkt_desc_t header_decode(data_t w);
        pkt_desc_t d;
        d.crc    = '0;
        d.length = w[7:0];
        d.prio   = w[10:8];
        d.dest   = w[14:11];
        return d;
    endfunction

    // control word: priority 2..0, crc 18..3, length 26..19, upper bits zero
    function automatic data_t ctrl_word(pkt_desc_t d);
        return data_t'({d.length, d.crc, d.prio});
    endfunction

endpackage

/* tb_in_module.sv */
module tb_in_module;

    import switch_pkg::*;

    localparam int BEAT_TIMEOUT  = 2000;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int STALL_TIMEOUT = 5000;

    typedef struct packed {
        port_sel_t dest;
        data_t     word;
    } beat_t;

    logic      in_clk;
    logic      out_clk;
    logic      reset;
    logic      wr_sop;
    logic      wr_eop;
    logic      wr_vld;
    data_t     wr_data;
    logic      wr_ready;
    logic      ready_in;
    logic      vld;
    data_t     data;
    port_sel_t rx;

    integer seed;
    beat_t  exp_q[$];
    logic   checking;
    logic   hold_low;
    logic   rand_ready;
    logic   hold_pending;
    data_t  held_data;
    int     value_errors;
    int     stall_errors;
    int     beats_checked;

    in_module UUT (
        .in_clk   (in_clk),
        .out_clk  (out_clk),
        .reset    (reset),
        .wr_sop   (wr_sop),
        .wr_eop   (wr_eop),
        .wr_vld   (wr_vld),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .ready_in (ready_in),
        .vld      (vld),
        .data     (data),
        .rx       (rx)
    );

    always #5 in_clk = ~in_clk;
    always #7 out_clk = ~out_clk;

    always @(posedge out_clk) begin
        ready_in <= hold_low ? 1'b0 : (rand_ready ? 1'($random(seed)) : 1'b1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // bit-serial crc, every word msb first
    function automatic crc_t crc_ref(input data_t words[$]);
        crc_t c;
        logic fb;
        c = CRC_INIT;
        foreach (words[k]) begin
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                fb = c[15] ^ words[k][b];
                c  = {c[14:0], 1'b0};
                if (fb) begin
                    c = c ^ CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: value %0d, stall %0d, beats checked %0d",
                 value_errors, stall_errors, beats_checked);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writer side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_beat(input data_t w, input logic sop, input logic eop);
        int gap;
        int waited;
        gap = $random(seed) & 7;
        if (gap > 4) begin
            wr_vld <= 1'b0;
            repeat (gap - 4) @(posedge in_clk);
        end
        wr_vld  <= 1'b1;
        wr_sop  <= sop;
        wr_eop  <= eop;
        wr_data <= w;
        waited = 0;
        @(posedge in_clk);
        // the beat is taken on the first edge that sees wr_ready high
        while (!wr_ready) begin
            waited++;
            if (waited > BEAT_TIMEOUT) begin
                abort_run("timeout waiting for wr_ready");
            end
            @(posedge in_clk);
        end
    endtask

    task automatic send_packet(input port_sel_t dest, input priority_t prio, input length_t len);
        data_t words[$];
        crc_t  crc;
        beat_t b;
        for (int i = 0; i < len; i++) begin
            words.push_back($random(seed));
        end
        crc = crc_ref(words);
        b.dest = dest;
        b.word = {5'b0, len, crc, prio};
        exp_q.push_back(b);
        foreach (words[i]) begin
            b.word = words[i];
            exp_q.push_back(b);
        end
        drive_beat({17'b0, dest, prio, len}, 1'b1, 1'b0);
        foreach (words[i]) begin
            drive_beat(words[i], 1'b0, i == len - 1);
        end
        wr_vld <= 1'b0;
        wr_sop <= 1'b0;
        wr_eop <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge out_clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                abort_run("timeout waiting for output beat");
            end
        end
        repeat (20) @(posedge out_clk);
        @(posedge in_clk);
    endtask

    task automatic watch_stall();
        int low_run;
        int waited;
        low_run = 0;
        waited  = 0;
        while (low_run < 40) begin
            @(posedge in_clk);
            waited++;
            if (waited > STALL_TIMEOUT) begin
                abort_run("wr_ready never stayed low while ready_in was held low");
            end
            low_run = wr_ready ? 0 : low_run + 1;
        end
        hold_low = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge out_clk) begin
        if (checking) begin
            if (hold_pending) begin
                assert (vld && data == held_data) else begin
                    stall_errors++;
                    $display("FAILED at %0t: beat changed while stalled, vld %b data %h held %h",
                             $time, vld, data, held_data);
                end
            end
            if (vld && ready_in) begin
                if (exp_q.size() == 0) begin
                    value_errors++;
                    $display("FAILED at %0t: beat %h arrived with no packet outstanding",
                             $time, data);
                end else begin
                    assert (data == exp_q[0].word) else begin
                        value_errors++;
                        $display("FAILED at %0t: data %h, expected %h",
                                 $time, data, exp_q[0].word);
                    end
                    assert (rx == exp_q[0].dest) else begin
                        value_errors++;
                        $display("FAILED at %0t: rx %0d, expected %0d", $time, rx, exp_q[0].dest);
                    end
                    void'(exp_q.pop_front());
                    beats_checked++;
                end
            end
            hold_pending = vld && !ready_in;
            held_data    = data;
        end
    end

    initial begin
        seed          = 39;
        in_clk        = 1'b0;
        out_clk       = 1'b0;
        reset         = 1'b1;
        wr_sop        = 1'b0;
        wr_eop        = 1'b0;
        wr_vld        = 1'b0;
        wr_data       = '0;
        ready_in      = 1'b0;
        checking      = 1'b0;
        hold_low      = 1'b0;
        rand_ready    = 1'b0;
        hold_pending  = 1'b0;
        held_data     = '0;
        value_errors  = 0;
        stall_errors  = 0;
        beats_checked = 0;

        repeat (2) @(posedge in_clk);
        reset <= 1'b0;
        @(posedge in_clk);
        checking = 1'b1;
        assert (!vld && wr_ready) else begin
            value_errors++;
            $display("FAILED at %0t: after reset vld %b wr_ready %b", $time, vld, wr_ready);
        end

        // single packet with ready_in high
        send_packet(4'd5, 3'd3, 8'd8);
        wait_drain();

        // random back-pressure on the output
        rand_ready = 1'b1;
        send_packet(4'd9, 3'd6, 8'd40);
        wait_drain();

        // back-to-back packets with the length extremes
        send_packet(4'd1, 3'd0, 8'd1);
        send_packet(4'd15, 3'd7, 8'd255);
        send_packet(4'd7, 3'd2, 8'd17);
        send_packet(4'd0, 3'd5, 8'd2);
        wait_drain();

        // two long packets against a blocked output fill the FIFO
        hold_low = 1'b1;
        fork
            begin
                send_packet(4'd12, 3'd4, 8'd255);
                send_packet(4'd3, 3'd1, 8'd255);
            end
            watch_stall();
        join
        wait_drain();

        $display("errors: value %0d, stall %0d, beats checked %0d",
                 value_errors, stall_errors, beats_checked);
        if (value_errors == 0 && stall_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
